//--- src/backtrack_config.svh
// Width, depth and threshold macros for the backtrack response router.
// Included by the package and by every module that sizes logic from them.
// The include guard lets several files pull it into one compilation unit.

`ifndef BACKTRACK_CONFIG_SVH
`define BACKTRACK_CONFIG_SVH

// Response word width
`define BT_DATA_W        32

// Lane and bundle counts of the overlay
`define BT_NUM_LANES     4
`define BT_NUM_BUNDLES   4

// FIFO depths
`define BT_ENGINE_DEPTH  16
`define BT_LANE_DEPTH    16

// Lane mark, leaves headroom for pops still in flight through the gate
`define BT_PROG_FULL     12

`endif

//--- src/backtrack_pkg.sv
// Shared types of the backtrack response router.
// Modules refer to these by scoped name, sized from the config macros.

`include "backtrack_config.svh"

package backtrack_pkg;

    // ----------------------------------------
    // Occupancy count sizing
    // ----------------------------------------
    // Largest FIFO in the design sets the count width
    localparam int max_depth = (`BT_ENGINE_DEPTH > `BT_LANE_DEPTH) ?
                               `BT_ENGINE_DEPTH : `BT_LANE_DEPTH;
    // One extra value so a full FIFO can be counted
    localparam int count_w   = $clog2(max_depth + 1);

    // ----------------------------------------
    // Typedefs
    // ----------------------------------------
    typedef logic [`BT_DATA_W-1:0]      resp_data_t;
    typedef logic [`BT_NUM_LANES-1:0]   lane_mask_t;
    // One bit per bundle, only one set
    typedef logic [`BT_NUM_BUNDLES-1:0] bundle_onehot_t;
    typedef logic [count_w-1:0]         fifo_count_t;

endpackage

//--- src/backtrack_sync_fifo.sv
// Single clock FIFO used for the engine buffer and each backtrack lane.
// Read data is registered, so a word shows up the cycle after rd_en.
// prog_full rises once occupancy reaches prog_full_level.
// Reads while empty and writes while full are ignored.

module backtrack_sync_fifo #(
    parameter int depth           = 16,
    parameter int prog_full_level = 12
) (
    input  logic                      ap_clk,
    input  logic                      areset_backtrack,
    input  logic                      wr_en,
    input  backtrack_pkg::resp_data_t wr_data,
    input  logic                      rd_en,
    output backtrack_pkg::resp_data_t rd_data,
    output logic                      empty,
    output logic                      full,
    output logic                      prog_full
);

    // Pointer width, at least one bit
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    // ----------------------------------------
    // Storage and state
    // ----------------------------------------
    backtrack_pkg::resp_data_t   mem [depth];
    logic [ptr_w-1:0]            wr_ptr;
    logic [ptr_w-1:0]            rd_ptr;
    backtrack_pkg::fifo_count_t  count;
    logic                        do_wr;
    logic                        do_rd;

    // Wrap at depth-1, depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Qualified strobes
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous read and write leaves count unchanged
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Data path, no reset
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // Status levels
    assign empty     = (count == '0);
    assign full      = (count == backtrack_pkg::fifo_count_t'(depth));
    assign prog_full = (count >= backtrack_pkg::fifo_count_t'(prog_full_level));

endmodule

//--- src/backtrack_response_signal.sv
// Read gate for the engine response FIFO.
// Latches the route on config_valid and decides whether the engine may pop,
// based on the prog_full levels of the lanes that the route reaches.
// Inputs are registered once and the decision once more, so engine_rd_en
// follows a prog_full or config change after two cycles.

`include "backtrack_config.svh"

module backtrack_response_signal #(
    parameter int bundle_id = 0
) (
    input  logic                          ap_clk,
    input  logic                          areset_backtrack,
    input  logic                          config_valid,
    input  backtrack_pkg::bundle_onehot_t config_id_bundle,
    input  backtrack_pkg::lane_mask_t     config_id_lane,
    input  logic                          engine_not_empty,
    input  backtrack_pkg::lane_mask_t     lane_prog_full,
    output logic                          engine_rd_en,
    output logic                          route_valid,
    output backtrack_pkg::lane_mask_t     route_lane,
    output logic                          route_local
);

    // Index of the lane that leads on to the next bundle
    localparam int last_lane = `BT_NUM_LANES - 1;

    // Next bundle, one-hot of bundle_id+1 with wrap
    localparam backtrack_pkg::bundle_onehot_t next_bundle =
        backtrack_pkg::bundle_onehot_t'(1) << ((bundle_id + 1) % `BT_NUM_BUNDLES);

    // ----------------------------------------
    // Registered inputs and route
    // ----------------------------------------
    backtrack_pkg::bundle_onehot_t route_bundle;
    backtrack_pkg::lane_mask_t     lane_prog_full_reg;
    logic                          engine_not_empty_reg;
    backtrack_pkg::lane_mask_t     lane_permit;
    logic                          rd_en_next;

    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            route_valid          <= 1'b0;
            route_bundle         <= '0;
            route_lane           <= '0;
            engine_not_empty_reg <= 1'b0;
            lane_prog_full_reg   <= '0;
        end else begin
            engine_not_empty_reg <= engine_not_empty;
            lane_prog_full_reg   <= lane_prog_full;
            // Route holds until the next config pulse
            if (config_valid) begin
                route_valid  <= 1'b1;
                route_bundle <= config_id_bundle;
                route_lane   <= config_id_lane;
            end
        end
    end

    // Local when the target bundle is our neighbour
    assign route_local = (route_bundle == next_bundle);

    // ----------------------------------------
    // Per-lane read permission
    // ----------------------------------------
    always_comb begin
        // No route yet, no pops
        lane_permit = '0;
        if (route_valid) begin
            if (route_lane == '0) begin
                // Drop route, nothing to back-pressure
                lane_permit = '1;
            end else if (route_local) begin
                for (int i = 0; i < `BT_NUM_LANES; i++) begin
                    lane_permit[i] = route_lane[i] ? ~lane_prog_full_reg[i] : 1'b1;
                end
            end else begin
                // Remote traffic only leaves through the last lane
                lane_permit            = '1;
                lane_permit[last_lane] = route_lane[last_lane] ?
                                         ~lane_prog_full_reg[last_lane] : 1'b1;
            end
        end
    end

    // Every lane must agree and the engine must hold data
    assign rd_en_next = (&lane_permit) & engine_not_empty_reg;

    // Second register stage of the decision
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            engine_rd_en <= 1'b0;
        end else begin
            engine_rd_en <= rd_en_next;
        end
    end

endmodule

//--- src/backtrack_lane_distributor.sv
// Fans a popped engine word out to the lanes chosen by the route.
// The pop strobe is delayed one cycle to line up with the FIFO's
// registered read data, so each lane write lands one cycle after the pop.

`include "backtrack_config.svh"

module backtrack_lane_distributor (
    input  logic                      ap_clk,
    input  logic                      areset_backtrack,
    input  logic                      engine_rd_en,
    input  backtrack_pkg::resp_data_t engine_rd_data,
    input  logic                      route_local,
    input  backtrack_pkg::lane_mask_t route_lane,
    output backtrack_pkg::lane_mask_t lane_wr_en,
    output backtrack_pkg::resp_data_t lane_wr_data
);

    localparam int last_lane = `BT_NUM_LANES - 1;

    // Pop seen last cycle, data valid now
    logic pop_q;

    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= engine_rd_en;
        end
    end

    // ----------------------------------------
    // Lane write strobes
    // ----------------------------------------
    always_comb begin
        lane_wr_en = '0;
        if (pop_q) begin
            if (route_local) begin
                // Every selected lane, empty mask writes nothing
                lane_wr_en = route_lane;
            end else if (|route_lane) begin
                // Onward to next bundle
                lane_wr_en[last_lane] = 1'b1;
            end
            // Empty remote mask falls through, word dropped
        end
    end

    // Same word to every lane
    assign lane_wr_data = engine_rd_data;

endmodule

//--- src/backtrack_response_router.sv
// Top level of one bundle's backtrack response router.
// Response words enter the engine FIFO, the gate decides when to pop it,
// and the distributor writes each popped word into the routed lane FIFOs.
// Each lane is drained by its own lane_rd_en bit.

`include "backtrack_config.svh"

module backtrack_response_router #(
    parameter int bundle_id = 0
) (
    input  logic                          ap_clk,
    input  logic                          areset_backtrack,
    input  logic                          config_valid,
    input  backtrack_pkg::bundle_onehot_t config_id_bundle,
    input  backtrack_pkg::lane_mask_t     config_id_lane,
    input  logic                          in_valid,
    input  backtrack_pkg::resp_data_t     in_data,
    output logic                          in_full,
    input  backtrack_pkg::lane_mask_t     lane_rd_en,
    output backtrack_pkg::resp_data_t     lane_data [`BT_NUM_LANES],
    output backtrack_pkg::lane_mask_t     lane_empty
);

    // ----------------------------------------
    // Internal signals
    // ----------------------------------------
    logic                      engine_empty;
    logic                      engine_not_empty;
    logic                      engine_rd_en;
    logic                      engine_pop;
    backtrack_pkg::resp_data_t engine_rd_data;
    logic                      route_valid;
    logic                      route_local;
    backtrack_pkg::lane_mask_t route_lane;
    backtrack_pkg::lane_mask_t lane_prog_full;
    backtrack_pkg::lane_mask_t lane_wr_en;
    backtrack_pkg::resp_data_t lane_wr_data;

    assign engine_not_empty = ~engine_empty;

    // Gate sees the FIFO level two cycles late and may still strobe
    // on a FIFO that just ran dry
    // Only real pops reach the lanes
    assign engine_pop = engine_rd_en & engine_not_empty;

    // Engine buffer whose full flag is the input back-pressure
    backtrack_sync_fifo #(
        .depth           (`BT_ENGINE_DEPTH),
        .prog_full_level (`BT_ENGINE_DEPTH)
    ) engine_fifo_i (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .wr_en            (in_valid),
        .wr_data          (in_data),
        .rd_en            (engine_pop),
        .rd_data          (engine_rd_data),
        .empty            (engine_empty),
        .full             (in_full),
        .prog_full        ()
    );

    backtrack_response_signal #(
        .bundle_id (bundle_id)
    ) response_signal_i (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .config_valid     (config_valid),
        .config_id_bundle (config_id_bundle),
        .config_id_lane   (config_id_lane),
        .engine_not_empty (engine_not_empty),
        .lane_prog_full   (lane_prog_full),
        .engine_rd_en     (engine_rd_en),
        .route_valid      (route_valid),
        .route_lane       (route_lane),
        .route_local      (route_local)
    );

    backtrack_lane_distributor lane_distributor_i (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .engine_rd_en     (engine_pop & route_valid),
        .engine_rd_data   (engine_rd_data),
        .route_local      (route_local),
        .route_lane       (route_lane),
        .lane_wr_en       (lane_wr_en),
        .lane_wr_data     (lane_wr_data)
    );

    // ----------------------------------------
    // Backtrack lane FIFOs
    // ----------------------------------------
    for (genvar i = 0; i < `BT_NUM_LANES; i++) begin : g_lane
        backtrack_sync_fifo #(
            .depth           (`BT_LANE_DEPTH),
            .prog_full_level (`BT_PROG_FULL)
        ) lane_fifo_i (
            .ap_clk           (ap_clk),
            .areset_backtrack (areset_backtrack),
            .wr_en            (lane_wr_en[i]),
            .wr_data          (lane_wr_data),
            .rd_en            (lane_rd_en[i]),
            .rd_data          (lane_data[i]),
            .empty            (lane_empty[i]),
            .full             (),
            .prog_full        (lane_prog_full[i])
        );
    end

endmodule

//--- verification/backtrack_tb_clock.sv
// Clock and reset source for the backtrack router testbench.
// 40 ns clock period, reset held high for the first three rising edges.

module backtrack_tb_clock (
    output logic ap_clk,
    output logic areset_backtrack
);
    timeunit 1ns;
    timeprecision 100ps;

    // Half of the 40 ns period
    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    initial begin
        areset_backtrack = 1'b1;
        repeat (3) @(posedge ap_clk);
        areset_backtrack <= 1'b0;
    end

endmodule

//--- verification/backtrack_assert.sv
// Concurrent checks on the router top level, attached with bind.
// Covers input overrun, the state right after reset and lane back-pressure.
// fail_count is read by the testbench top when it closes the run.

`include "backtrack_config.svh"

module backtrack_assert (
    input logic                      ap_clk,
    input logic                      areset_backtrack,
    input logic                      config_valid,
    input logic                      in_valid,
    input logic                      in_full,
    input logic                      engine_rd_en,
    input logic                      route_local,
    input backtrack_pkg::lane_mask_t route_lane,
    input backtrack_pkg::lane_mask_t lane_prog_full,
    input backtrack_pkg::lane_mask_t lane_wr_en,
    input backtrack_pkg::lane_mask_t lane_empty
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Source never strobes into a full engine FIFO
    no_write_when_full: assert property (@(posedge ap_clk) disable iff (areset_backtrack)
        in_valid |-> !in_full)
        else begin
            fail_count++;
            $error("in_valid strobed while in_full was high");
        end

    // First cycle out of reset, everything idle
    idle_after_reset: assert property (@(posedge ap_clk)
        $fell(areset_backtrack) |->
            (lane_wr_en == '0 && lane_empty == '1 && !engine_rd_en && !in_full))
        else begin
            fail_count++;
            $error("lane or engine strobes active right after reset");
        end

    // ----------------------------------------
    // Lane mark stops engine pops
    // ----------------------------------------
    // Route must hold for the two-stage gate, hence no config pulse
    for (genvar i = 0; i < `BT_NUM_LANES; i++) begin : g_lane
        pop_stops_at_mark: assert property (@(posedge ap_clk) disable iff (areset_backtrack)
            (route_local && route_lane[i] && lane_prog_full[i] && !config_valid)
                |-> ##2 !engine_rd_en)
            else begin
                fail_count++;
                $error("engine pop two cycles after lane %0d reached its mark", i);
            end
    end

endmodule

bind backtrack_response_router backtrack_assert assert_i (
    .ap_clk           (ap_clk),
    .areset_backtrack (areset_backtrack),
    .config_valid     (config_valid),
    .in_valid         (in_valid),
    .in_full          (in_full),
    .engine_rd_en     (engine_rd_en),
    .route_local      (route_local),
    .route_lane       (route_lane),
    .lane_prog_full   (lane_prog_full),
    .lane_wr_en       (lane_wr_en),
    .lane_empty       (lane_empty)
);

//--- verification/backtrack_checker.sv
// Scoreboard for the backtrack router.
// Tracks the configured route, predicts the lanes of every accepted word
// and compares each lane read against the expected queue of that lane.

`include "backtrack_config.svh"

module backtrack_checker #(
    parameter int bundle_id = 0
) (
    input logic                           ap_clk,
    input logic                           areset_backtrack,
    input logic                           config_valid,
    input backtrack_pkg::bundle_onehot_t  config_id_bundle,
    input backtrack_pkg::lane_mask_t      config_id_lane,
    input logic                           in_valid,
    input backtrack_pkg::resp_data_t      in_data,
    input logic                           in_full,
    input backtrack_pkg::lane_mask_t      lane_rd_en,
    input backtrack_pkg::resp_data_t      lane_data [`BT_NUM_LANES],
    input backtrack_pkg::lane_mask_t      lane_empty
);
    timeunit 1ns;
    timeprecision 100ps;

    int error_count   = 0;
    int checked_count = 0;

    backtrack_pkg::resp_data_t      expected [`BT_NUM_LANES][$];
    backtrack_pkg::bundle_onehot_t  model_bundle;
    backtrack_pkg::lane_mask_t      model_mask;
    // Reads issued last edge, data due now
    backtrack_pkg::lane_mask_t      read_pending;

    // Lanes that receive a word under the given route
    function automatic backtrack_pkg::lane_mask_t target_lanes(
        input backtrack_pkg::bundle_onehot_t bundle,
        input backtrack_pkg::lane_mask_t     mask
    );
        backtrack_pkg::bundle_onehot_t neighbour;
        neighbour = '0;
        neighbour[(bundle_id + 1) % `BT_NUM_BUNDLES] = 1'b1;
        if (mask == '0) begin
            return '0;
        end
        if (bundle == neighbour) begin
            return mask;
        end
        // Any other bundle leaves through the last lane
        return backtrack_pkg::lane_mask_t'(1) << (`BT_NUM_LANES - 1);
    endfunction

    // ----------------------------------------
    // Model update and compare
    // ----------------------------------------
    always @(posedge ap_clk) begin
        backtrack_pkg::lane_mask_t targets;
        backtrack_pkg::resp_data_t want;
        if (areset_backtrack) begin
            read_pending = '0;
        end else begin
            for (int i = 0; i < `BT_NUM_LANES; i++) begin
                if (read_pending[i]) begin
                    if (expected[i].size() == 0) begin
                        error_count++;
                        $display("error: lane_data[%0d] got 0x%08h, no word expected",
                                 i, lane_data[i]);
                    end else begin
                        want = expected[i].pop_front();
                        if (lane_data[i] !== want) begin
                            error_count++;
                            $display("error: lane_data[%0d] got 0x%08h, expected 0x%08h",
                                     i, lane_data[i], want);
                        end else begin
                            checked_count++;
                        end
                    end
                end
            end
            // A read of an empty lane returns nothing
            read_pending = lane_rd_en & ~lane_empty;
            if (config_valid) begin
                model_bundle = config_id_bundle;
                model_mask   = config_id_lane;
            end
            if (in_valid && !in_full) begin
                targets = target_lanes(model_bundle, model_mask);
                for (int i = 0; i < `BT_NUM_LANES; i++) begin
                    if (targets[i]) begin
                        expected[i].push_back(in_data);
                    end
                end
            end
        end
    end

    // Words that never came out, reported per lane
    function automatic int leftover_words();
        int total;
        total = 0;
        for (int i = 0; i < `BT_NUM_LANES; i++) begin
            if (expected[i].size() != 0) begin
                $display("Lane %0d still expects %0d words that never arrived",
                         i, expected[i].size());
                total += expected[i].size();
            end
        end
        return total;
    endfunction

endmodule

//--- verification/backtrack_tb.sv
// Testbench top for the backtrack response router, bundle 1.
// Runs local, remote, drop, back-pressure and reroute scenarios,
// then prints the error counts and the final verdict.

`include "backtrack_config.svh"

module backtrack_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int bundle_id   = 1;
    localparam int n_local     = 24;
    localparam int n_remote    = 24;
    localparam int n_drop      = 24;
    localparam int n_pressure  = 48;
    // Words per route in the reroute scenario, which uses two routes
    localparam int n_reroute   = 16;
    localparam int total_words = n_local + n_remote + n_drop + n_pressure + 2 * n_reroute;
    // 40 cycles per word plus margin for reset and drains
    localparam int watchdog_cycles = total_words * 40 + 2000;
    // Engine depth plus gate latency
    localparam int flush_cycles = `BT_ENGINE_DEPTH + 4;

    logic                          ap_clk;
    logic                          areset_backtrack;
    logic                          config_valid;
    backtrack_pkg::bundle_onehot_t config_id_bundle;
    backtrack_pkg::lane_mask_t     config_id_lane;
    logic                          in_valid;
    backtrack_pkg::resp_data_t     in_data;
    logic                          in_full;
    backtrack_pkg::lane_mask_t     lane_rd_en = '0;
    backtrack_pkg::resp_data_t     lane_data [`BT_NUM_LANES];
    backtrack_pkg::lane_mask_t     lane_empty;
    logic                          drain_on   = 1'b0;
    int                            other_errors = 0;

    backtrack_tb_clock clock_i (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack)
    );

    backtrack_response_router #(
        .bundle_id (bundle_id)
    ) dut_i (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .config_valid     (config_valid),
        .config_id_bundle (config_id_bundle),
        .config_id_lane   (config_id_lane),
        .in_valid         (in_valid),
        .in_data          (in_data),
        .in_full          (in_full),
        .lane_rd_en       (lane_rd_en),
        .lane_data        (lane_data),
        .lane_empty       (lane_empty)
    );

    backtrack_checker #(
        .bundle_id (bundle_id)
    ) checker_i (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .config_valid     (config_valid),
        .config_id_bundle (config_id_bundle),
        .config_id_lane   (config_id_lane),
        .in_valid         (in_valid),
        .in_data          (in_data),
        .in_full          (in_full),
        .lane_rd_en       (lane_rd_en),
        .lane_data        (lane_data),
        .lane_empty       (lane_empty)
    );

    // Random lane drains while enabled
    always @(posedge ap_clk) begin
        if (drain_on) begin
            lane_rd_en <= backtrack_pkg::lane_mask_t'($urandom());
        end else begin
            lane_rd_en <= '0;
        end
    end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic set_route(input backtrack_pkg::bundle_onehot_t bundle,
                             input backtrack_pkg::lane_mask_t mask);
        @(posedge ap_clk);
        config_valid     <= 1'b1;
        config_id_bundle <= bundle;
        config_id_lane   <= mask;
        @(posedge ap_clk);
        config_valid     <= 1'b0;
    endtask

    task automatic write_words(input int count);
        int   sent;
        logic wrote_last;
        sent       = 0;
        wrote_last = 1'b0;
        while (sent < count) begin
            @(posedge ap_clk);
            // in_full here is the pre-edge level
            // One idle cycle after a write keeps a FIFO that just filled from being strobed
            if (!in_full && !wrote_last && $urandom_range(3) != 0) begin
                in_valid   <= 1'b1;
                in_data    <= $urandom();
                wrote_last = 1'b1;
                sent++;
            end else begin
                in_valid   <= 1'b0;
                wrote_last = 1'b0;
            end
        end
        @(posedge ap_clk);
        in_valid <= 1'b0;
    endtask

    // Engine and lanes quiet for several cycles in a row
    task automatic wait_drained();
        int quiet;
        quiet = 0;
        while (quiet < 8) begin
            @(posedge ap_clk);
            if (dut_i.engine_empty && lane_empty == '1) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic close_run();
        int missing;
        int total;
        missing = checker_i.leftover_words();
        total   = checker_i.error_count + dut_i.assert_i.fail_count + other_errors + missing;
        $display("Errors compare %0d, assert %0d, other %0d, missing %0d, words checked %0d",
                 checker_i.error_count, dut_i.assert_i.fail_count, other_errors, missing,
                 checker_i.checked_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // ----------------------------------------
    // Scenarios
    // ----------------------------------------
    initial begin
        void'($urandom(32'h153d_b2f8));
        config_valid     = 1'b0;
        config_id_bundle = '0;
        config_id_lane   = '0;
        in_valid         = 1'b0;
        in_data          = '0;
        @(negedge areset_backtrack);
        @(posedge ap_clk);

        // Local route to bundle 2 through lanes 0 and 2
        set_route(4'b0100, 4'b0101);
        drain_on <= 1'b1;
        write_words(n_local);
        wait_drained();

        // Remote route to bundle 3 that only lane 3 carries
        set_route(4'b1000, 4'b0110);
        write_words(n_remote);
        wait_drained();

        // Empty mask drops every word
        set_route(4'b0100, 4'b0000);
        write_words(n_drop);
        // Nothing back-pressures a drop route
        repeat (flush_cycles) @(posedge ap_clk);
        if (in_full || !dut_i.engine_empty) begin
            other_errors++;
            $display("Engine FIFO still holds dropped words %0d cycles after input stopped",
                     flush_cycles);
        end
        wait_drained();

        // Back-pressure with lanes held until the engine FIFO fills
        drain_on <= 1'b0;
        set_route(4'b0100, 4'b1011);
        fork
            write_words(n_pressure);
            begin
                wait (in_full);
                @(posedge ap_clk);
                drain_on <= 1'b1;
            end
        join
        wait_drained();

        // Reroute from local lane 1 to remote bundle 0
        set_route(4'b0100, 4'b0010);
        write_words(n_reroute);
        wait_drained();
        set_route(4'b0001, 4'b0011);
        write_words(n_reroute);
        wait_drained();

        repeat (4) @(posedge ap_clk);
        close_run();
    end

    // Watchdog sized from the total word count
    initial begin
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("Run stopped by the watchdog after %0d cycles", watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- backtrack_response_router.f
+incdir+src
src/backtrack_pkg.sv
src/backtrack_sync_fifo.sv
src/backtrack_response_signal.sv
src/backtrack_lane_distributor.sv
src/backtrack_response_router.sv
verification/backtrack_tb_clock.sv
verification/backtrack_assert.sv
verification/backtrack_checker.sv
verification/backtrack_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the backtrack router testbench with Verilator and runs it.
# The exit status is zero only when the run ends with the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module backtrack_tb -f backtrack_response_router.f -o backtrack_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Assertion errors must not stop the run before the closing line
output=$(./obj_dir/backtrack_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
